// File: common/vt_defs.svh
// ------------------
// VT bench constants
// ------------------
`ifndef VT_DEFS_SVH
`define VT_DEFS_SVH

// uart
`define VT_CLKS_PER_BIT      16   // sim value, board uses far more

// buttons
`define VT_DEBOUNCE_CYCLES   8    // stable cycles before accept

// power rails
`define VT_NUM_RAILS         6
`define VT_PWR_STEP_CYCLES   32   // spacing between rail changes

// panel scan
`define VT_LINE_CYCLES       24
`define VT_LINES_PER_FRAME   16
`define VT_PAT_NUM           12   // patterns 0..11
`define VT_PAT_W             4
`define VT_NUM_MUX           14   // analog switch channels

`endif

// File: common/vt_pkg.sv
// ------------------
// VT shared types
// ------------------
`include "vt_defs.svh"

package vt_pkg;

    // host command opcode, upper nibble of the byte
    typedef enum logic [3:0] {
        CMD_NOP     = 4'd0,
        CMD_SET_PAT = 4'd1,
        CMD_PWR_ON  = 4'd2,
        CMD_PWR_OFF = 4'd3,
        CMD_STATUS  = 4'd4
    } cmd_op_e;

    typedef enum logic [1:0] {
        PWR_OFF       = 2'd0,
        PWR_RAMP_UP   = 2'd1,
        PWR_ON        = 2'd2,
        PWR_RAMP_DOWN = 2'd3
    } pwr_state_e;

    typedef logic [`VT_PAT_W-1:0] pattern_t;

    // switch-on order, first field first
    typedef struct packed {
        logic p14v;
        logic n14v;
        logic gvddp;
        logic gvddn;
        logic vgh;
        logic vgl;
    } rail_en_t;

    typedef struct packed {
        logic       active;  // drive the panel
        logic       stv;
        logic [3:0] ckv;
        logic [2:0] ckh;     // r, g, b
        logic       u2d;
        logic       d2u;
        logic       grst;
    } gate_timing_t;

    typedef enum logic [1:0] {
        LVL_FLOAT = 2'd0,
        LVL_LOW   = 2'd1,
        LVL_HIGH  = 2'd2
    } level_e;

    typedef level_e [`VT_NUM_MUX-1:0] mux_bus_t;

endpackage

// File: uart/uart_rx.sv
// ------------------
// UART 8N1 receiver
// ------------------
`timescale 1ns/1ps
`include "vt_defs.svh"

module uart_rx (
    input  logic       clk,
    input  logic       rst,
    input  logic       rxd,
    output logic [7:0] rx_data,
    output logic       rx_valid
);
    localparam int CW = $clog2(`VT_CLKS_PER_BIT);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    rx_state_e     state;
    logic [1:0]    rxd_sync;
    logic [CW-1:0] clk_cnt;
    logic [2:0]    bit_cnt;
    logic [7:0]    shift;
    logic          bit_end;
    logic          sample;
    logic          stop_ok;

    assign bit_end = clk_cnt == CW'(`VT_CLKS_PER_BIT - 1);
    assign sample  = (state == RX_DATA) && bit_end;
    assign stop_ok = (state == RX_STOP) && bit_end && rxd_sync[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= RX_IDLE;
            rxd_sync <= 2'b11;     // line idles high
            clk_cnt  <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rxd_sync <= {rxd_sync[0], rxd};
            rx_valid <= stop_ok;   // mid stop bit
            clk_cnt  <= clk_cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (!rxd_sync[1])
                        state <= RX_START;
                end
                RX_START: begin
                    if (clk_cnt == CW'(`VT_CLKS_PER_BIT / 2 - 1)) begin
                        clk_cnt <= '0;
                        bit_cnt <= '0;
                        state   <= rxd_sync[1] ? RX_IDLE : RX_DATA;  // glitch check
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        clk_cnt <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7)
                            state <= RX_STOP;
                    end
                end
                default: begin
                    if (bit_end)
                        state <= RX_IDLE;  // low stop bit drops the frame
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (sample)
            shift <= {rxd_sync[1], shift[7:1]};  // lsb first
        if (stop_ok)
            rx_data <= shift;
    end

    a_valid_single: assert property (@(posedge clk) disable iff (rst)
        rx_valid |=> !rx_valid) else $error("rx_valid held two cycles");

endmodule

// File: uart/uart_tx.sv
// ------------------
// UART 8N1 transmitter
// ------------------
`timescale 1ns/1ps
`include "vt_defs.svh"

module uart_tx (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] tx_data,
    input  logic       tx_start,
    output logic       txd,
    output logic       tx_busy
);
    localparam int CW = $clog2(`VT_CLKS_PER_BIT);

    typedef enum logic {TX_IDLE, TX_SHIFT} tx_state_e;

    tx_state_e     state;
    logic [CW-1:0] clk_cnt;
    logic [3:0]    bit_cnt;   // 0 start, 1..8 data, 9 stop
    logic [8:0]    frame;     // data then stop bit
    logic          bit_end;
    logic          load;
    logic          shift_en;

    assign bit_end  = clk_cnt == CW'(`VT_CLKS_PER_BIT - 1);
    assign load     = (state == TX_IDLE) && tx_start;
    assign shift_en = (state == TX_SHIFT) && bit_end && (bit_cnt != 4'd9);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= TX_IDLE;
            txd     <= 1'b1;
            tx_busy <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (load) begin
            state   <= TX_SHIFT;
            txd     <= 1'b0;       // start bit
            tx_busy <= 1'b1;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (state == TX_SHIFT) begin
            clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
            if (shift_en) begin
                txd     <= frame[0];
                bit_cnt <= bit_cnt + 1'b1;
            end else if (bit_end) begin
                state   <= TX_IDLE;   // stop bit done
                tx_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load)
            frame <= {1'b1, tx_data};
        else if (shift_en)
            frame <= {1'b1, frame[8:1]};
    end

    a_start_idle: assert property (@(posedge clk) disable iff (rst)
        tx_start |-> !tx_busy) else $error("tx_start while busy");

endmodule

// File: rtl/cmd_ctrl.sv
// ------------------
// command and button control
// ------------------
`timescale 1ns/1ps
`include "vt_defs.svh"

module cmd_ctrl import vt_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] rx_data,
    input  logic       rx_valid,
    input  logic       sw_next,
    input  logic       sw_prev,
    input  logic       sw_pwr,
    input  pwr_state_e pwr_state,
    input  logic       tx_busy,
    output pattern_t   pattern,
    output logic       pwr_on_req,
    output logic       pwr_off_req,
    output logic [7:0] tx_data,
    output logic       tx_start
);
    localparam int DW = $clog2(`VT_DEBOUNCE_CYCLES);

    logic [2:0]    sw_meta;
    logic [2:0]    sw_sync;
    logic [2:0]    sw_stable;
    logic [2:0]    sw_press;    // next, prev, pwr
    logic [DW-1:0] db_cnt [3];
    cmd_op_e       op;
    logic          status_req;
    logic          status_pend;
    logic          send;

    assign op         = cmd_op_e'(rx_data[7:4]);
    assign status_req = rx_valid && (op == CMD_STATUS);
    assign send       = status_pend && !tx_busy && !tx_start;

    // --------------------
    // button debounce
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            sw_meta   <= '0;
            sw_sync   <= '0;
            sw_stable <= '0;
            sw_press  <= '0;
            for (int i = 0; i < 3; i++)
                db_cnt[i] <= '0;
        end else begin
            sw_meta <= {sw_pwr, sw_prev, sw_next};
            sw_sync <= sw_meta;
            for (int i = 0; i < 3; i++) begin
                sw_press[i] <= 1'b0;
                if (sw_sync[i] == sw_stable[i]) begin
                    db_cnt[i] <= '0;
                end else if (db_cnt[i] == DW'(`VT_DEBOUNCE_CYCLES - 1)) begin
                    db_cnt[i]    <= '0;
                    sw_stable[i] <= sw_sync[i];
                    sw_press[i]  <= sw_sync[i];  // rising edge only
                end else begin
                    db_cnt[i] <= db_cnt[i] + 1'b1;
                end
            end
        end
    end

    // --------------------
    // decode and status
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            pattern     <= '0;
            pwr_on_req  <= 1'b0;
            pwr_off_req <= 1'b0;
            status_pend <= 1'b0;
            tx_start    <= 1'b0;
        end else begin
            pwr_on_req  <= 1'b0;
            pwr_off_req <= 1'b0;
            tx_start    <= send;
            status_pend <= send ? status_req : (status_pend | status_req);  // merge
            if (rx_valid) begin
                case (op)
                    CMD_SET_PAT: if (rx_data[3:0] < `VT_PAT_NUM) pattern <= rx_data[3:0];
                    CMD_PWR_ON:  pwr_on_req  <= (pwr_state == PWR_OFF);
                    CMD_PWR_OFF: pwr_off_req <= (pwr_state == PWR_ON);
                    default: ;   // nop and status
                endcase
            end else if (sw_press[0]) begin
                pattern <= (pattern == pattern_t'(`VT_PAT_NUM - 1)) ? '0 : pattern + 1'b1;
            end else if (sw_press[1]) begin
                pattern <= (pattern == '0) ? pattern_t'(`VT_PAT_NUM - 1) : pattern - 1'b1;
            end else if (sw_press[2]) begin
                pwr_on_req  <= (pwr_state == PWR_OFF);   // ramps ignore it
                pwr_off_req <= (pwr_state == PWR_ON);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (send)
            tx_data <= {pwr_state, 2'b00, pattern};
    end

    a_pat_range: assert property (@(posedge clk) disable iff (rst)
        pattern < `VT_PAT_NUM) else $error("pattern out of range");

endmodule

// File: rtl/power_seq.sv
// ------------------
// rail sequencer
// ------------------
`timescale 1ns/1ps
`include "vt_defs.svh"

module power_seq import vt_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       pwr_on_req,
    input  logic       pwr_off_req,
    output rail_en_t   rails,
    output pwr_state_e pwr_state
);
    localparam int SW = $clog2(`VT_PWR_STEP_CYCLES);
    localparam int NR = `VT_NUM_RAILS;

    logic [SW-1:0] step_cnt;
    logic [2:0]    rail_idx;
    logic [NR-1:0] rail_q;      // msb is first rail on
    logic          step_done;
    logic          last_rail;

    assign step_done = step_cnt == SW'(`VT_PWR_STEP_CYCLES - 1);
    assign last_rail = rail_idx == 3'(NR - 1);
    assign rails     = rail_en_t'(rail_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            pwr_state <= PWR_OFF;
            rail_q    <= '0;
            step_cnt  <= '0;
            rail_idx  <= '0;
        end else begin
            step_cnt <= step_done ? '0 : step_cnt + 1'b1;
            if (step_done && pwr_state inside {PWR_RAMP_UP, PWR_RAMP_DOWN})
                rail_idx <= last_rail ? '0 : rail_idx + 1'b1;
            case (pwr_state)
                PWR_OFF: if (pwr_on_req) begin
                    pwr_state <= PWR_RAMP_UP;
                    step_cnt  <= SW'(1);   // counts the request cycle
                    rail_idx  <= '0;
                end
                PWR_RAMP_UP: if (step_done) begin
                    rail_q <= {1'b1, rail_q[NR-1:1]};
                    if (last_rail)
                        pwr_state <= PWR_ON;
                end
                PWR_ON: if (pwr_off_req) begin
                    pwr_state <= PWR_RAMP_DOWN;
                    step_cnt  <= SW'(1);
                    rail_idx  <= '0;
                end
                default: if (step_done) begin
                    rail_q <= {rail_q[NR-2:0], 1'b0};  // reverse order
                    if (last_rail)
                        pwr_state <= PWR_OFF;
                end
            endcase
        end
    end

    a_rail_order: assert property (@(posedge clk) disable iff (rst)
        ((rail_q & ~(rail_q >> 1)) & {1'b0, {(NR-1){1'b1}}}) == '0)
        else $error("rail on before an earlier rail");

endmodule

// File: rtl/panel_timing.sv
// ------------------
// gate and source timing
// ------------------
`timescale 1ns/1ps
`include "vt_defs.svh"

module panel_timing import vt_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  pwr_state_e   pwr_state,
    input  pattern_t     pattern,
    output gate_timing_t timing
);
    localparam int CW = $clog2(`VT_LINE_CYCLES);
    localparam int LW = $clog2(`VT_LINES_PER_FRAME);

    logic [CW-1:0] cyc_cnt;
    logic [LW-1:0] line_cnt;
    pattern_t      pat_q;
    logic          run;
    logic          black;
    logic          second_half;
    logic [1:0]    phase;

    assign run         = pwr_state == PWR_ON;
    assign black       = pattern == '0;
    assign second_half = cyc_cnt >= CW'(`VT_LINE_CYCLES / 2);
    assign phase       = pattern[3] ? 2'd3 - line_cnt[1:0] : line_cnt[1:0];  // mirror on reverse

    // --------------------
    // line and frame counters
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            cyc_cnt  <= '0;
            line_cnt <= '0;
            pat_q    <= '0;
        end else begin
            pat_q <= pattern;
            if (!run || pattern != pat_q) begin
                cyc_cnt  <= '0;    // hold or restart frame
                line_cnt <= '0;
            end else if (cyc_cnt == CW'(`VT_LINE_CYCLES - 1)) begin
                cyc_cnt  <= '0;
                line_cnt <= (line_cnt == LW'(`VT_LINES_PER_FRAME - 1)) ? '0 : line_cnt + 1'b1;
            end else begin
                cyc_cnt <= cyc_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        timing        = '0;
        timing.active = run;
        timing.u2d    = !pattern[3];
        timing.d2u    = pattern[3];
        timing.grst   = black;        // black pattern keeps gates reset
        if (!black) begin
            timing.stv        = line_cnt == '0;
            timing.ckv[phase] = 1'b1;
            timing.ckh        = pattern[2:0] & {3{second_half}};
        end
    end

endmodule

// File: rtl/level_encoder.sv
// ------------------
// analog switch levels
// ------------------
`timescale 1ns/1ps
`include "vt_defs.svh"

module level_encoder import vt_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  gate_timing_t timing,
    output mux_bus_t     mux
);
    logic [`VT_NUM_MUX-1:0] raw;

    // channel 0 stv .. 10 grst, top three tied high
    assign raw = {3'b111, timing.grst, timing.d2u, timing.u2d,
                  timing.ckh, timing.ckv, timing.stv};

    always_ff @(posedge clk) begin
        for (int i = 0; i < `VT_NUM_MUX; i++) begin
            if (rst || !timing.active)
                mux[i] <= LVL_FLOAT;
            else
                mux[i] <= raw[i] ? LVL_HIGH : LVL_LOW;
        end
    end

endmodule

// File: rtl/vt_top.sv
// ------------------
// VT test controller top
// ------------------
`timescale 1ns/1ps

module vt_top import vt_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     rxd,
    input  logic     sw_next,
    input  logic     sw_prev,
    input  logic     sw_pwr,
    output logic     txd,
    output rail_en_t rails,
    output mux_bus_t mux
);
    logic [7:0]   rx_data;
    logic         rx_valid;
    logic [7:0]   tx_data;
    logic         tx_start;
    logic         tx_busy;
    pattern_t     pattern;
    logic         pwr_on_req;
    logic         pwr_off_req;
    pwr_state_e   pwr_state;
    gate_timing_t timing;

    uart_rx u_uart_rx (.clk(clk), .rst(rst), .rxd(rxd), .rx_data(rx_data), .rx_valid(rx_valid));

    uart_tx u_uart_tx (.clk(clk), .rst(rst), .tx_data(tx_data), .tx_start(tx_start),
                       .txd(txd), .tx_busy(tx_busy));

    cmd_ctrl u_cmd_ctrl (
        .clk(clk), .rst(rst), .rx_data(rx_data), .rx_valid(rx_valid),
        .sw_next(sw_next), .sw_prev(sw_prev), .sw_pwr(sw_pwr),
        .pwr_state(pwr_state), .tx_busy(tx_busy), .pattern(pattern),
        .pwr_on_req(pwr_on_req), .pwr_off_req(pwr_off_req),
        .tx_data(tx_data), .tx_start(tx_start)
    );

    power_seq u_power_seq (.clk(clk), .rst(rst), .pwr_on_req(pwr_on_req),
                           .pwr_off_req(pwr_off_req), .rails(rails), .pwr_state(pwr_state));

    panel_timing u_panel_timing (.clk(clk), .rst(rst), .pwr_state(pwr_state),
                                 .pattern(pattern), .timing(timing));

    level_encoder u_level_encoder (.clk(clk), .rst(rst), .timing(timing), .mux(mux));

endmodule

// File: verif/tb_clk.sv
// --------------------
// testbench clock
// --------------------
`timescale 1ns/1ps

module tb_clk #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);
    initial clk = 1'b0;

    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

// File: verif/tb_top.sv
// --------------------
// VT testbench top
// --------------------
`timescale 1ns/1ps
`include "vt_defs.svh"

module tb_top import vt_pkg::*; ();
    localparam int CLK_NS    = 40;
    localparam int BIT_CYC   = `VT_CLKS_PER_BIT;
    localparam int FRAME_CYC = `VT_LINE_CYCLES * `VT_LINES_PER_FRAME;
    localparam int RAMP_CYC  = `VT_NUM_RAILS * `VT_PWR_STEP_CYCLES;
    localparam int UART_CYC  = 2 * 10 * BIT_CYC;     // command plus reply
    localparam int HOLD_CYC  = `VT_DEBOUNCE_CYCLES + 4;
    localparam int NUM_CMDS  = 30;
    localparam int WD_CYCLES = 2 * NUM_CMDS * (FRAME_CYC + RAMP_CYC + UART_CYC);

    logic       clk;
    logic       rst;
    logic       rxd;
    logic       txd;
    logic [2:0] buttons;     // next, prev, pwr
    rail_en_t   rails;
    mux_bus_t   mux;
    logic [5:0] rail_bits;
    logic [13:0] hi_ch;
    logic [13:0] lo_ch;
    logic       check_en;    // panel checks, off while pattern moves
    logic       panel_chk;
    logic [3:0] exp_pat;
    pwr_state_e exp_pwr;
    logic [7:0] lfsr;
    int         assert_errs;
    int         timeout_errs;

    tb_clk #(.PERIOD_NS(CLK_NS)) u_clk (.clk(clk));

    vt_top u_dut (
        .clk(clk), .rst(rst), .rxd(rxd),
        .sw_next(buttons[0]), .sw_prev(buttons[1]), .sw_pwr(buttons[2]),
        .txd(txd), .rails(rails), .mux(mux)
    );

    assign rail_bits = rails;
    assign panel_chk = check_en && (exp_pwr == PWR_ON);

    always_comb begin
        for (int i = 0; i < `VT_NUM_MUX; i++) begin
            hi_ch[i] = mux[i] == LVL_HIGH;
            lo_ch[i] = mux[i] == LVL_LOW;
        end
    end

    // --------------------
    // assertions
    // --------------------
    a_reset_state: assert property (@(posedge clk) $fell(rst) |-> (rail_bits == '0 && mux == '0 && txd))
        else begin assert_errs++; $display("Error @%0t: state after reset", $time); end
    a_rail_order: assert property (@(posedge clk) disable iff (rst)
        (6'(rail_bits << 1) & ~rail_bits) == '0)
        else begin assert_errs++; $display("Error @%0t: rail order %b", $time, rail_bits); end
    a_rail_step: assert property (@(posedge clk) disable iff (rst)
        $countones(rail_bits ^ $past(rail_bits)) <= 1)
        else begin assert_errs++; $display("Error @%0t: rails jumped", $time); end
    a_off_state: assert property (@(posedge clk) disable iff (rst)
        exp_pwr == PWR_OFF |-> rail_bits == '0)
        else begin assert_errs++; $display("Error @%0t: rails on while off", $time); end
    a_on_state: assert property (@(posedge clk) disable iff (rst)
        exp_pwr == PWR_ON |-> (rail_bits == '1 && hi_ch[13:11] == 3'b111))
        else begin assert_errs++; $display("Error @%0t: powered state wrong", $time); end
    a_float: assert property (@(posedge clk) disable iff (rst) rail_bits != '1 |-> mux == '0)
        else begin assert_errs++; $display("Error @%0t: mux driven unpowered", $time); end
    a_black: assert property (@(posedge clk) disable iff (rst)
        (panel_chk && exp_pat == 4'd0) |-> (hi_ch[10] && lo_ch[7:0] == 8'hff))
        else begin assert_errs++; $display("Error @%0t: black pattern levels", $time); end
    a_one_ckv: assert property (@(posedge clk) disable iff (rst)
        (panel_chk && exp_pat != 4'd0) |-> $onehot(hi_ch[4:1]))
        else begin assert_errs++; $display("Error @%0t: ckv not one-hot", $time); end
    // line 0 carries stv, and its gate clock is the first one in scan order
    a_stv_line: assert property (@(posedge clk) disable iff (rst)
        (panel_chk && exp_pat != 4'd0 && hi_ch[0]) |->
        (lo_ch[10] && (exp_pat[3] ? hi_ch[4] : hi_ch[1])))
        else begin assert_errs++; $display("Error @%0t: stv line levels", $time); end
    a_scan_dir: assert property (@(posedge clk) disable iff (rst)
        panel_chk |-> (hi_ch[8] == !exp_pat[3] && hi_ch[9] == exp_pat[3]))
        else begin assert_errs++; $display("Error @%0t: scan direction", $time); end
    a_ckh_off: assert property (@(posedge clk) disable iff (rst)
        panel_chk |-> (lo_ch[7:5] | exp_pat[2:0]) == 3'b111)
        else begin assert_errs++; $display("Error @%0t: unused ckh active", $time); end

    // --------------------
    // helpers
    // --------------------
    task automatic step(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);   // galois, x^8+x^6+x^5+x^4+1
    endfunction

    function automatic logic [3:0] take_random_nibble();
        logic [3:0] v;
        for (int i = 0; i < 4; i++) begin
            v[i] = lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    task automatic uart_send(input logic [7:0] data);
        rxd = 1'b0;                         // start bit
        step(BIT_CYC);
        for (int i = 0; i < 8; i++) begin
            rxd = data[i];
            step(BIT_CYC);
        end
        rxd = 1'b1;
        step(BIT_CYC);
    endtask

    task automatic uart_recv(output logic [7:0] data);
        int n;
        n = 0;
        data = 'x;
        while (txd !== 1'b0 && n < 2 * UART_CYC) begin
            step(1);
            n++;
        end
        if (txd !== 1'b0) begin
            timeout_errs++;
            $display("no reply start bit seen on txd in time");
        end else begin
            step(BIT_CYC / 2);              // to mid start bit
            for (int i = 0; i < 8; i++) begin
                step(BIT_CYC);
                data[i] = txd;
            end
            step(BIT_CYC);
            assert (txd === 1'b1) else begin
                assert_errs++;
                $display("Error @%0t: reply stop bit low", $time);
            end
        end
    endtask

    task automatic check_status(input int replies);
        logic [7:0] got [2];
        logic [7:0] expected;
        expected = {exp_pwr, 2'b00, exp_pat};
        fork
            repeat (replies) uart_send({CMD_STATUS, 4'h0});
            for (int i = 0; i < replies; i++) uart_recv(got[i]);
        join
        for (int i = 0; i < replies; i++) begin
            assert (got[i] === expected) else begin
                assert_errs++;
                $display("Error @%0t: status %h, expected %h", $time, got[i], expected);
            end
        end
    endtask

    task automatic wait_rails(input logic [5:0] target);
        int n;
        n = 0;
        while (rail_bits !== target && n < RAMP_CYC + 64) begin
            step(1);
            n++;
        end
        if (rail_bits !== target) begin
            timeout_errs++;
            $display("rails did not reach %b in time", target);
        end
    endtask

    task automatic press_button(input int idx);
        buttons[idx] = 1'b1;
        step(HOLD_CYC);
        buttons[idx] = 1'b0;
        step(HOLD_CYC);                     // let the release settle too
    endtask

    task automatic set_pattern(input logic [3:0] arg);
        check_en = 1'b0;
        uart_send({CMD_SET_PAT, arg});
        if (arg < `VT_PAT_NUM)
            exp_pat = arg;
        step(2);
        check_en = 1'b1;
        step(FRAME_CYC);
    endtask

    task automatic step_pattern(input logic up);
        check_en = 1'b0;
        press_button(up ? 0 : 1);
        if (up)
            exp_pat = (exp_pat == 4'd11) ? 4'd0 : exp_pat + 4'd1;
        else
            exp_pat = (exp_pat == 4'd0) ? 4'd11 : exp_pat - 4'd1;
        step(2);
        check_en = 1'b1;
        step(FRAME_CYC);
    endtask

    task automatic power_up(input logic by_button);
        exp_pwr = PWR_RAMP_UP;
        if (by_button)
            press_button(2);
        else
            uart_send({CMD_PWR_ON, 4'h0});
        wait_rails(6'h3f);
        step(1);                            // mux lags by one cycle
        exp_pwr = PWR_ON;
    endtask

    task automatic power_down(input logic by_button);
        exp_pwr = PWR_RAMP_DOWN;
        if (by_button)
            press_button(2);
        else
            uart_send({CMD_PWR_OFF, 4'h0});
        wait_rails(6'h00);
        exp_pwr = PWR_OFF;
    endtask

    // --------------------
    // stimulus
    // --------------------
    initial begin
        rst = 1'b1;
        rxd = 1'b1;
        buttons = '0;
        check_en = 1'b1;
        exp_pat = 4'd0;
        exp_pwr = PWR_OFF;
        lfsr = 8'd78;
        assert_errs = 0;
        timeout_errs = 0;
        step(8);
        rst = 1'b0;
        step(4);
        check_status(1);

        power_up(1'b0);
        step(FRAME_CYC);                    // black pattern frame
        check_status(1);

        set_pattern(4'd11);
        check_status(1);
        step_pattern(1'b1);                 // wraps to 0
        check_status(1);
        step_pattern(1'b0);                 // back to 11
        check_status(1);
        repeat (6) begin
            set_pattern(take_random_nibble());
            check_status(1);
        end
        set_pattern(4'd15);                 // out of range, ignored
        check_status(1);
        set_pattern(4'd9);                  // reverse scan, red only
        check_status(1);

        power_down(1'b0);
        check_status(1);
        power_up(1'b1);
        step(FRAME_CYC);
        check_status(1);
        power_down(1'b1);
        check_status(1);

        check_status(2);                    // second request lands mid reply
        step(4);

        $display("checks done: %0d assertion errors, %0d timeouts", assert_errs, timeout_errs);
        if (assert_errs == 0 && timeout_errs == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        #(WD_CYCLES * CLK_NS);
        $display("watchdog expired before the tests completed");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: tb.f
+incdir+common
common/vt_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
rtl/cmd_ctrl.sv
rtl/power_seq.sv
rtl/panel_timing.sv
rtl/level_encoder.sv
rtl/vt_top.sv
verif/tb_clk.sv
verif/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# Verilator build and run of the VT testbench

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_top \
    -f tb.f -Mdir obj_dir > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "compile failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/Vtb_top > "$SIM_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status, see $SIM_LOG"
    exit 1
fi

if grep -qx "Simulation finished: PASS" "$SIM_LOG"; then
    echo "test passed"
    exit 0
fi
echo "test failed, see $SIM_LOG"
exit 1
